// ==== compile.f ====
+incdir+.
ssb_pkg.sv
ssb_stream_if.sv
sample_discriminator.sv
sample_buffer.sv
sample_packer.sv
capture_control.sv
sparse_sample_buffer.sv
ssb_checker.sv
tb_sparse_sample_buffer.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, failing status on any failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_sparse_sample_buffer -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_sparse_sample_buffer > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
if ! grep -q "All tests passed" sim.log; then
  echo "simulation log has no result line"
  exit 1
fi
exit 0

// ==== tb_sparse_sample_buffer.sv ====
// testbench: directed and random captures, reference model of the packets
// and a compare process on the output stream
`default_nettype none
`include "ssb_macros.svh"

module tb_sparse_sample_buffer;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 3000;

  logic                         clk = 1'b0;
  logic                         reset;
  logic [`SSB_SAMPLE_WIDTH-1:0] sample_in, threshold_low, threshold_high;
  logic                         sample_valid, config_valid, cmd_valid, cmd_ready;
  ssb_pkg::cmd_e                cmd;
  logic [`SSB_OUT_WIDTH-1:0]    out_data;
  logic                         out_valid, out_ready, out_last;

  logic [`SSB_SAMPLE_WIDTH-1:0] stim[$];  // samples of the next capture
  logic [`SSB_OUT_WIDTH:0]      exp_q[$]; // {last, word} not yet seen
  bit                           back_pressure;
  bit                           timed_out;
  int                           rx_count, test_errors, tests_passed, tests_failed;
  int                           checker_errors;
  string                        test_name;

  sparse_sample_buffer i_sparse_sample_buffer (.*);

  always #50 clk = ~clk;

  // discriminator rule with full-stop, then two samples per word, low half first
  function automatic void ssb_model(input logic [15:0] samples[$], input logic [15:0] lo, hi,
                                    output logic [31:0] ts_words[$],
                                    output logic [31:0] data_words[$], output bit full_stop);
    logic [15:0] kept[$];
    logic [25:0] stime = '0; // valid samples seen so far
    logic [5:0]  didx = '0;
    bit          pulse = 1'b0;
    bit          start;
    bit          keep;
    full_stop = 1'b0;
    foreach (samples[i]) begin
      if (!full_stop) begin
        start = !pulse && (samples[i] > hi);
        keep  = start || (pulse && (samples[i] >= lo));
        if (start) ts_words.push_back({stime, didx});
        if (keep) begin
          kept.push_back(samples[i]);
          didx++;
        end
        if (start) pulse = 1'b1;
        else if (pulse && (samples[i] < lo)) pulse = 1'b0;
        stime++;
        // a full buffer ends capture right after this write
        full_stop = (ts_words.size() == `SSB_TS_DEPTH) || (kept.size() == `SSB_DATA_DEPTH);
      end
    end
    for (int i = 0; i < kept.size(); i += 2) begin
      data_words.push_back({(i + 1 < kept.size()) ? kept[i+1] : 16'h0000, kept[i]});
    end
  endfunction

  // out_valid and out_data are settled by the falling edge
  initial begin
    logic [`SSB_OUT_WIDTH:0] expected;
    out_ready = 1'b0;
    forever begin
      @(negedge clk);
      out_ready = back_pressure ? ($urandom_range(3) != 0) : 1'b1;
      if (out_valid) begin // commands are closed during readout
        assert (!cmd_ready) else begin
          $display("MISMATCH time=%0t cmd_ready got=%b expected=%b", $time, cmd_ready, 1'b0);
          test_errors++;
        end
      end
      if (out_valid && out_ready) begin // transfer at the next rising edge
        rx_count++;
        assert (exp_q.size() > 0) else begin
          $display("extra output word %h at time %0t, none expected", out_data, $time);
          test_errors++;
        end
        if (exp_q.size() > 0) begin
          expected = exp_q.pop_front();
          assert (out_data == expected[31:0]) else begin
            $display("MISMATCH time=%0t out_data got=%h expected=%h",
                     $time, out_data, expected[31:0]);
            test_errors++;
          end
          assert (out_last == expected[32]) else begin
            $display("MISMATCH time=%0t out_last got=%b expected=%b",
                     $time, out_last, expected[32]);
            test_errors++;
          end
        end
      end
    end
  end

  task automatic check_count(input string what, input int got, input int expected);
    assert (got == expected) else begin
      $display("MISMATCH time=%0t %s got=%0d expected=%0d", $time, what, got, expected);
      test_errors++;
    end
  endtask

  // 4-digit decimal fields separated by one space
  task automatic load_samples(input string text);
    string field;
    stim.delete();
    for (int i = 0; i + 3 < text.len(); i += 5) begin
      field = text.substr(i, i + 3);
      stim.push_back(16'(field.atoi()));
    end
  endtask

  task automatic send_command(input ssb_pkg::cmd_e op);
    int cycles = 0;
    if (timed_out) return;
    while (!cmd_ready && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (!cmd_ready) begin
      $display("TIMEOUT: cmd_ready stayed low, command %s not sent", op.name());
      timed_out = 1'b1;
    end else begin
      cmd       = op;
      cmd_valid = 1'b1;
      @(negedge clk); // accepted on this rising edge
      cmd_valid = 1'b0;
    end
  endtask

  // readout is over once every word arrived and the FSM is back in idle
  task automatic wait_readout();
    int cycles = 0;
    if (timed_out) return;
    while (!(exp_q.size() == 0 && cmd_ready) && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (!(exp_q.size() == 0 && cmd_ready)) begin
      $display("TIMEOUT: readout not finished, %0d words still missing", exp_q.size());
      timed_out = 1'b1;
    end
  endtask

  task automatic run_capture(input logic [15:0] lo, hi, input bit gaps);
    logic [31:0] ts_words[$];
    logic [31:0] data_words[$];
    bit          full_stop;
    int          expected_count;
    if (timed_out) return;
    ssb_model(stim, lo, hi, ts_words, data_words, full_stop);
    foreach (ts_words[i]) exp_q.push_back({i == ts_words.size() - 1, ts_words[i]});
    foreach (data_words[i]) exp_q.push_back({i == data_words.size() - 1, data_words[i]});
    expected_count = exp_q.size();
    rx_count       = 0;
    threshold_low  = lo;
    threshold_high = hi;
    config_valid   = 1'b1;
    @(negedge clk);
    config_valid = 1'b0;
    send_command(ssb_pkg::cmd_start);
    if (timed_out) return;
    foreach (stim[i]) begin
      if (gaps && $urandom_range(3) == 0) begin
        sample_valid = 1'b0; // idle cycle with a junk payload
        sample_in    = 16'($urandom);
        @(negedge clk);
      end
      sample_in    = stim[i];
      sample_valid = 1'b1;
      @(negedge clk);
    end
    sample_valid = 1'b0;
    repeat (2) @(negedge clk); // last writes land before the stop
    if (!full_stop) send_command(ssb_pkg::cmd_stop);
    wait_readout();
    check_count("output word count", rx_count, expected_count);
  endtask

  task automatic open_test(input string name);
    test_name     = name;
    test_errors   = 0;
    back_pressure = 1'b0;
  endtask

  task automatic close_test();
    if (test_errors == 0 && !timed_out) begin
      tests_passed++;
      $display("test %s: ok, %0d words", test_name, rx_count);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", test_name, test_errors);
    end
  endtask

  initial begin
    void'($urandom(32'hd42d));
    reset          = 1'b1;
    sample_in      = '0;
    sample_valid   = 1'b0;
    threshold_low  = '0;
    threshold_high = '0;
    config_valid   = 1'b0;
    cmd            = ssb_pkg::cmd_start;
    cmd_valid      = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    open_test("single pulse");
    check_count("cmd_ready after reset", cmd_ready, 1);
    load_samples("0010 0020 0050 1500 1600 0900 0200 0050 0030 0030");
    run_capture(16'd100, 16'd1000, 1'b0);
    close_test();

    open_test("hysteresis");
    load_samples("0500 1200 0700 0300 0080 0600 0999 1001 0150 0050 2000 0100 0099 0020");
    run_capture(16'd100, 16'd1000, 1'b0);
    close_test();

    open_test("data buffer overflow");
    stim.delete();
    for (int i = 0; i < 70; i++) stim.push_back(16'(2000 + i));
    run_capture(16'd100, 16'd1000, 1'b0);
    check_count("data words read", rx_count - 1, `SSB_DATA_DEPTH / 2); // one ts word first
    close_test();

    open_test("timestamp buffer overflow");
    stim.delete();
    for (int p = 0; p < 17; p++) begin
      stim.push_back(16'(1500 + p));
      stim.push_back(16'd1200);
      stim.push_back(16'd10);
    end
    run_capture(16'd100, 16'd1000, 1'b0);
    check_count("timestamp plus data words", rx_count, `SSB_TS_DEPTH + 16); // 31 samples kept
    close_test();

    open_test("random stream with back-pressure");
    stim.delete();
    for (int i = 0; i < 60; i++) stim.push_back(16'($urandom_range(4000)));
    back_pressure = 1'b1;
    run_capture(16'd1000, 16'd3000, 1'b1);
    close_test();

    open_test("odd count and empty capture");
    load_samples("0010 1500 1400 0300 0005 0008");
    run_capture(16'd100, 16'd1000, 1'b0);
    load_samples("0010 0500 0900 1000 0040");
    run_capture(16'd100, 16'd1000, 1'b0);
    check_count("words from an empty capture", rx_count, 0);
    close_test();

    checker_errors = i_sparse_sample_buffer.ssb_checker_i.error_count;
    $display("tests passed: %0d, tests failed: %0d, checker failures: %0d",
             tests_passed, tests_failed, checker_errors);
    if (tests_failed == 0 && !timed_out && checker_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== ssb_checker.sv ====
// concurrent checks on the output valid/ready handshake bound into the top level
`default_nettype none
`include "ssb_macros.svh"

module ssb_checker (
  input logic                      clk,
  input logic                      reset,
  input logic [`SSB_OUT_WIDTH-1:0] out_data,
  input logic                      out_valid,
  input logic                      out_ready,
  input logic                      out_last
);
  timeunit 1ns;
  timeprecision 1ps;

  int error_count = 0; // failed assertions so far

  // a stalled word keeps its payload until it is taken
  hold_stable: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
    else begin
      $error("output word changed or dropped while stalled");
      error_count++;
    end

  last_with_valid: assert property (@(posedge clk) disable iff (reset) out_last |-> out_valid)
    else begin
      $error("out_last high without out_valid");
      error_count++;
    end

  quiet_in_reset: assert property (@(posedge clk) reset |=> !out_valid)
    else begin
      $error("out_valid high after a reset cycle");
      error_count++;
    end

endmodule

bind sparse_sample_buffer ssb_checker ssb_checker_i (
  .clk       (clk),
  .reset     (reset),
  .out_data  (out_data),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_last  (out_last)
);

`default_nettype wire

// ==== sparse_sample_buffer.sv ====
// top level: discriminator, data and timestamp buffers, packer and controller
`default_nettype none
`include "ssb_macros.svh"

module sparse_sample_buffer (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [`SSB_SAMPLE_WIDTH-1:0] sample_in,
  input  logic                         sample_valid,   // realtime, never stalled
  input  logic [`SSB_SAMPLE_WIDTH-1:0] threshold_low,
  input  logic [`SSB_SAMPLE_WIDTH-1:0] threshold_high,
  input  logic                         config_valid,
  input  ssb_pkg::cmd_e                cmd,
  input  logic                         cmd_valid,
  output logic                         cmd_ready,
  output logic [`SSB_OUT_WIDTH-1:0]    out_data,
  output logic                         out_valid,
  input  logic                         out_ready,
  output logic                         out_last
);

  localparam int TS_WIDTH = $bits(ssb_pkg::timestamp_t);

  logic clear, capture_en;
  logic ts_read_en, data_read_en;
  logic ts_full, data_full;
  logic ts_empty, data_empty;

  ssb_stream_if #(.WIDTH(`SSB_SAMPLE_WIDTH)) disc_data_s ();
  ssb_stream_if #(.WIDTH(TS_WIDTH))          disc_ts_s ();
  ssb_stream_if #(.WIDTH(TS_WIDTH))          ts_rd_s ();
  ssb_stream_if #(.WIDTH(`SSB_SAMPLE_WIDTH)) data_rd_s ();
  ssb_stream_if #(.WIDTH(`SSB_OUT_WIDTH))    pack_s ();

  sample_discriminator disc_i (
    .clk, .reset, .clear,
    .sample_in, .sample_valid,
    .threshold_low, .threshold_high, .config_valid,
    .capture_en,
    .ts_full,
    .data_out (disc_data_s),
    .ts_out   (disc_ts_s)
  );

  sample_buffer #(.WIDTH(`SSB_SAMPLE_WIDTH), .DEPTH(`SSB_DATA_DEPTH)) data_buffer_i (
    .clk, .reset, .clear, .capture_en,
    .read_en (data_read_en),
    .wr      (disc_data_s),
    .rd      (data_rd_s),
    .full    (data_full),
    .empty   (data_empty)
  );

  sample_buffer #(.WIDTH(TS_WIDTH), .DEPTH(`SSB_TS_DEPTH)) ts_buffer_i (
    .clk, .reset, .clear, .capture_en,
    .read_en (ts_read_en),
    .wr      (disc_ts_s),
    .rd      (ts_rd_s),
    .full    (ts_full),
    .empty   (ts_empty)
  );

  // data samples go out two per word
  sample_packer packer_i (
    .clk, .reset,
    .in  (data_rd_s),
    .out (pack_s)
  );

  capture_control control_i (
    .clk, .reset,
    .cmd, .cmd_valid, .cmd_ready,
    .ts_full, .data_full, .ts_empty, .data_empty,
    .clear, .capture_en, .ts_read_en, .data_read_en,
    .ts_rd   (ts_rd_s),
    .pack_rd (pack_s),
    .out_data, .out_valid, .out_last, .out_ready
  );

endmodule

`default_nettype wire

// ==== capture_control.sv ====
// command FSM with start/stop, stop on a full buffer and section skip on an empty buffer
// and routing of the timestamp then data packet to the output port
`default_nettype none
`include "ssb_macros.svh"

module capture_control (
  input  logic                      clk,
  input  logic                      reset,
  input  ssb_pkg::cmd_e             cmd,
  input  logic                      cmd_valid,
  output logic                      cmd_ready,
  input  logic                      ts_full,
  input  logic                      data_full,
  input  logic                      ts_empty,
  input  logic                      data_empty,
  output logic                      clear,
  output logic                      capture_en,
  output logic                      ts_read_en,
  output logic                      data_read_en,
  ssb_stream_if.sink                ts_rd,
  ssb_stream_if.sink                pack_rd,
  output logic [`SSB_OUT_WIDTH-1:0] out_data,
  output logic                      out_valid,
  output logic                      out_last,
  input  logic                      out_ready
);

  ssb_pkg::state_e state, state_next;
  ssb_pkg::state_e after_capture; // first non-empty section, or idle
  logic            cmd_fire;
  logic            stop_now;

  assign cmd_ready = (state == ssb_pkg::idle) || (state == ssb_pkg::capture);
  assign cmd_fire  = cmd_valid && cmd_ready; // mismatched opcodes are swallowed

  assign clear    = cmd_fire && (state == ssb_pkg::idle) && (cmd == ssb_pkg::cmd_start);
  assign stop_now = (cmd_fire && (cmd == ssb_pkg::cmd_stop)) || ts_full || data_full;

  // full on either side freezes both buffers in the same cycle
  assign capture_en   = (state == ssb_pkg::capture) && !ts_full && !data_full;
  assign ts_read_en   = (state == ssb_pkg::read_ts);
  assign data_read_en = (state == ssb_pkg::read_data);

  always_comb begin
    if (!ts_empty)        after_capture = ssb_pkg::read_ts;
    else if (!data_empty) after_capture = ssb_pkg::read_data;
    else                  after_capture = ssb_pkg::idle;
  end

  always_comb begin
    state_next = state;
    case (state)
      ssb_pkg::idle:    if (clear) state_next = ssb_pkg::capture;
      ssb_pkg::capture: if (stop_now) state_next = after_capture;
      ssb_pkg::read_ts: begin
        if (ts_rd.valid && ts_rd.ready && ts_rd.last) begin
          state_next = data_empty ? ssb_pkg::idle : ssb_pkg::read_data;
        end
      end
      ssb_pkg::read_data: begin
        if (pack_rd.valid && pack_rd.ready && pack_rd.last) state_next = ssb_pkg::idle;
      end
      default: state_next = ssb_pkg::idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) state <= ssb_pkg::idle;
    else       state <= state_next;
  end

  // only the selected stream sees ready
  assign ts_rd.ready   = (state == ssb_pkg::read_ts) && out_ready;
  assign pack_rd.ready = (state == ssb_pkg::read_data) && out_ready;

  always_comb begin
    case (state)
      ssb_pkg::read_ts: begin
        out_data  = ts_rd.data;
        out_valid = ts_rd.valid;
        out_last  = ts_rd.last;
      end
      ssb_pkg::read_data: begin
        out_data  = pack_rd.data;
        out_valid = pack_rd.valid;
        out_last  = pack_rd.last;
      end
      default: begin
        out_data  = pack_rd.data; // don't care while valid is low
        out_valid = 1'b0;
        out_last  = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== sample_packer.sv ====
// packs two samples into one output word with the first sample in the low half
// a last on the low half goes out with a zero high half
`default_nettype none
`include "ssb_macros.svh"

module sample_packer (
  input  logic         clk,
  input  logic         reset,
  ssb_stream_if.sink   in,
  ssb_stream_if.source out
);

  logic [`SSB_SAMPLE_WIDTH-1:0] low_half; // first sample of the pair
  logic                         have_low;
  logic                         in_fire;

  // accept input only when the output register can take a new word
  assign in.ready = !out.valid || out.ready;
  assign in_fire  = in.valid && in.ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      have_low  <= 1'b0;
      out.valid <= 1'b0;
      out.last  <= 1'b0;
    end else begin
      if (out.ready) begin
        out.valid <= 1'b0; // word taken
        out.last  <= 1'b0;
      end
      if (in_fire) begin
        if (!have_low && !in.last) begin
          have_low <= 1'b1;
        end else begin
          have_low  <= 1'b0;
          out.valid <= 1'b1;
          out.last  <= in.last;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      if (!have_low) begin
        low_half <= in.data;
        out.data <= {{`SSB_SAMPLE_WIDTH{1'b0}}, in.data}; // odd tail gets a zero high half
      end else begin
        out.data <= {in.data, low_half};
      end
    end
  end

endmodule

`default_nettype wire

// ==== sample_buffer.sv ====
// capture memory: gated write port, full/empty flags and a registered
// readout stream from entry 0 up to the write pointer
`default_nettype none

module sample_buffer #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 64
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        clear,
  input  logic        capture_en,
  input  logic        read_en,
  ssb_stream_if.sink  wr,
  ssb_stream_if.source rd,
  output logic        full,
  output logic        empty
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W:0]   wr_ptr; // one extra bit so full is distinct from empty
  logic [PTR_W:0]   rd_ptr;
  logic             wr_fire;
  logic             rd_fetch;

  assign full  = (wr_ptr == (PTR_W+1)'(DEPTH));
  assign empty = (wr_ptr == '0);

  // ready is informational only, the discriminator never waits
  assign wr.ready = capture_en && !full;
  assign wr_fire  = wr.valid && wr.ready;

  // fetch the next entry when the output register is free or draining
  assign rd_fetch = read_en && (rd_ptr != wr_ptr) && (!rd.valid || rd.ready);

  always_ff @(posedge clk) begin
    if (wr_fire) mem[wr_ptr[PTR_W-1:0]] <= wr.data;
  end

  always_ff @(posedge clk) begin
    if (rd_fetch) rd.data <= mem[rd_ptr[PTR_W-1:0]]; // 1 cycle read latency
  end

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      rd.valid <= 1'b0;
      rd.last  <= 1'b0;
    end else begin
      if (wr_fire) wr_ptr <= wr_ptr + 1'b1;
      if (rd_fetch) begin
        rd_ptr   <= rd_ptr + 1'b1;
        rd.valid <= 1'b1;
        rd.last  <= (rd_ptr + 1'b1 == wr_ptr); // final stored entry
      end else if (rd.ready) begin
        // transfer with nothing behind it
        rd.valid <= 1'b0;
        rd.last  <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== sample_discriminator.sv ====
// hysteresis pulse detector, emits stored samples and one timestamp per pulse start
// every output is registered once
`default_nettype none
`include "ssb_macros.svh"

module sample_discriminator (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         clear,
  input  logic [`SSB_SAMPLE_WIDTH-1:0] sample_in,
  input  logic                         sample_valid,
  input  logic [`SSB_SAMPLE_WIDTH-1:0] threshold_low,
  input  logic [`SSB_SAMPLE_WIDTH-1:0] threshold_high,
  input  logic                         config_valid,
  input  logic                         capture_en,
  input  logic                         ts_full,
  ssb_stream_if.source                 data_out,
  ssb_stream_if.source                 ts_out
);

  localparam int TIME_WIDTH = `SSB_OUT_WIDTH - `SSB_INDEX_WIDTH;

  logic [`SSB_SAMPLE_WIDTH-1:0] thr_low, thr_high;
  logic                         pulse_high;   // inside a pulse
  logic [TIME_WIDTH-1:0]        sample_time;
  logic [`SSB_INDEX_WIDTH-1:0]  data_index;   // next free data address
  logic                         take;         // valid sample during capture
  logic                         start_pulse;
  logic                         keep_sample;
  ssb_pkg::timestamp_t          ts_word;

  // thresholds follow the config port whenever it is valid
  always_ff @(posedge clk) begin
    if (config_valid) begin
      thr_low  <= threshold_low;
      thr_high <= threshold_high;
    end
  end

  always_comb begin
    take        = capture_en && sample_valid;
    start_pulse = !pulse_high && (sample_in > thr_high); // must clear the high level
    // inside a pulse only the low level matters
    keep_sample = start_pulse || (pulse_high && (sample_in >= thr_low));
    ts_word.sample_time = sample_time;
    ts_word.data_index  = data_index;
  end

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      pulse_high     <= 1'b0;
      sample_time    <= '0;
      data_index     <= '0;
      data_out.valid <= 1'b0;
      ts_out.valid   <= 1'b0;
    end else begin
      data_out.valid <= take && keep_sample;
      ts_out.valid   <= take && start_pulse && !ts_full; // dropped once the ts buffer is full
      if (take) begin
        sample_time <= sample_time + 1'b1;
        if (keep_sample) data_index <= data_index + 1'b1;
        if (start_pulse) begin
          pulse_high <= 1'b1;
        end else if (pulse_high && (sample_in < thr_low)) begin
          pulse_high <= 1'b0; // falling below low ends the pulse, sample not kept
        end
      end
    end
  end

  // payload follows every cycle, only valid qualifies it
  always_ff @(posedge clk) begin
    data_out.data <= sample_in;
    ts_out.data   <= ts_word;
  end

  assign data_out.last = 1'b0; // capture writes are not packetized
  assign ts_out.last   = 1'b0;

endmodule

`default_nettype wire

// ==== ssb_stream_if.sv ====
// valid/ready stream with last, used for every datapath link
`default_nettype none
`include "ssb_macros.svh"

interface ssb_stream_if #(
  parameter int WIDTH = `SSB_SAMPLE_WIDTH
) ();

  logic [WIDTH-1:0] data;
  logic             valid;
  logic             ready; // left unused on the discriminator links
  logic             last;  // marks the final beat of a packet

  modport source (
    output data, valid, last,
    input  ready
  );

  modport sink (
    input  data, valid, last,
    output ready
  );

  modport monitor (
    input data, valid, ready, last
  );

endinterface

`default_nettype wire

// ==== ssb_pkg.sv ====
// shared types: controller states, command opcodes, timestamp word layout
`default_nettype none
`include "ssb_macros.svh"

package ssb_pkg;

  typedef enum logic [0:0] {
    cmd_start = 1'b0, // arm capture, clears both buffers
    cmd_stop  = 1'b1  // end capture and start readout
  } cmd_e;

  typedef enum logic [1:0] {
    idle      = 2'd0,
    capture   = 2'd1,
    read_ts   = 2'd2, // timestamp packet
    read_data = 2'd3  // packed sample packet
  } state_e;

  // one word per pulse start, sample_time in the upper bits
  typedef struct packed {
    logic [`SSB_OUT_WIDTH-`SSB_INDEX_WIDTH-1:0] sample_time; // valid samples since start
    logic [`SSB_INDEX_WIDTH-1:0]                data_index;  // address of first stored sample
  } timestamp_t;

endpackage

`default_nettype wire

// ==== ssb_macros.svh ====
// sizing constants for the sparse sample buffer
// sample, buffer depth and output word widths
`ifndef SSB_MACROS_SVH
`define SSB_MACROS_SVH

// one raw adc sample
`define SSB_SAMPLE_WIDTH 16

// entries in the data buffer, one sample each
`define SSB_DATA_DEPTH 64

// entries in the timestamp buffer, one per pulse
`define SSB_TS_DEPTH 16

// packet word width on the output port
`define SSB_OUT_WIDTH 32

// address width of the data buffer, also the data_index field of a timestamp
`define SSB_INDEX_WIDTH 6

`endif
